//--- rtl/sv32_ptw_consts.svh
`ifndef SV32_PTW_CONSTS_SVH
`define SV32_PTW_CONSTS_SVH

// Sv32 address widths
`define PTW_VLEN 32
`define PTW_PLEN 34
`define PTW_PPNW 22
`define PTW_ASIDW 9

// one vpn field indexes a 1024 entry table
`define PTW_VPNW 10
`define PTW_PGOFF 12

// raw pte word
`define PTW_PTEW 32

// global mapping flag inside a pte
`define PTW_G_BIT 5

`endif

//--- rtl/sv32_ptw_pkg.sv
package sv32_ptw_pkg;

`include "sv32_ptw_consts.svh"

    // address and page number vectors
    typedef logic [`PTW_VLEN-1:0] vaddr_t;
    typedef logic [`PTW_PLEN-1:0] paddr_t;
    typedef logic [`PTW_PPNW-1:0] ppn_t;
    typedef logic [`PTW_ASIDW-1:0] asid_t;
    typedef logic [`PTW_VLEN-`PTW_PGOFF-1:0] vpn_t;
    typedef logic [`PTW_PTEW-1:0] pte_word_t;

    // walk FSM states
    typedef enum logic [2:0] {
        st_idle,
        st_wait_grant,
        st_pte_lookup,
        st_wait_rvalid,
        st_prop_error
    } walk_state_e;

    // Sv32 has two table levels, level 1 is the root
    typedef enum logic {
        lvl_1,
        lvl_2
    } ptw_level_e;

    // outcome of judging one pte
    typedef enum logic [1:0] {
        verdict_leaf_ok,
        verdict_next_level,
        verdict_fault
    } pte_verdict_e;

endpackage

//--- rtl/ptw_miss_arbiter.sv
`timescale 1ns/10ps

`include "sv32_ptw_consts.svh"

module ptw_miss_arbiter import sv32_ptw_pkg::*; (
    input  logic   clk_i,
    input  logic   rst_ni,
    input  logic   idle_i,
    input  logic   enable_translation_i,
    input  logic   en_ld_st_translation_i,
    input  logic   itlb_access_i,
    input  logic   itlb_hit_i,
    input  vaddr_t itlb_vaddr_i,
    input  logic   dtlb_access_i,
    input  logic   dtlb_hit_i,
    input  vaddr_t dtlb_vaddr_i,
    input  asid_t  asid_i,
    input  ppn_t   satp_ppn_i,
    output logic   start_o,
    output logic   is_instr_o,
    output vaddr_t walk_vaddr_o,
    output asid_t  walk_asid_o,
    output paddr_t root_pptr_o,
    output logic   itlb_miss_o,
    output logic   dtlb_miss_o
);

    logic   itlb_miss;
    logic   dtlb_miss;
    vaddr_t sel_vaddr;
    logic   is_instr_q;
    vaddr_t vaddr_q;
    asid_t  asid_q;
    paddr_t root_pptr_q;

    // ----------------------------------------
    // miss detection
    // ----------------------------------------
    // an access on the data side holds off the fetch walk
    assign itlb_miss = idle_i & enable_translation_i & itlb_access_i & ~itlb_hit_i
                     & ~dtlb_access_i;
    assign dtlb_miss = idle_i & ~itlb_miss & en_ld_st_translation_i & dtlb_access_i
                     & ~dtlb_hit_i;

    assign itlb_miss_o = itlb_miss;
    assign dtlb_miss_o = dtlb_miss;
    assign start_o     = itlb_miss | dtlb_miss;

    assign sel_vaddr = itlb_miss ? itlb_vaddr_i : dtlb_vaddr_i;

    // kind of walk in flight
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            is_instr_q <= 1'b0;
        end else if (start_o) begin
            is_instr_q <= itlb_miss;
        end
    end

    // request payload, root pte sits at satp.ppn * 4096 + vpn[1] * 4
    always_ff @(posedge clk_i) begin
        if (start_o) begin
            vaddr_q     <= sel_vaddr;
            asid_q      <= asid_i;
            root_pptr_q <= {satp_ppn_i, sel_vaddr[`PTW_VLEN-1 -: `PTW_VPNW], 2'b00};
        end
    end

    assign is_instr_o   = is_instr_q;
    assign walk_vaddr_o = vaddr_q;
    assign walk_asid_o  = asid_q;
    assign root_pptr_o  = root_pptr_q;

endmodule

//--- rtl/pte_checker.sv
`timescale 1ns/10ps

`include "sv32_ptw_consts.svh"

module pte_checker import sv32_ptw_pkg::*; (
    input  pte_word_t    pte_i,
    input  ptw_level_e   level_i,
    input  logic         is_instr_i,
    input  logic         is_store_i,
    input  logic         mxr_i,
    output pte_verdict_e verdict_o
);

    // pte flag fields
    logic pte_v;
    logic pte_r;
    logic pte_w;
    logic pte_x;
    logic pte_a;
    logic pte_d;
    ppn_t pte_ppn;
    logic invalid;
    logic is_leaf;
    logic instr_ok;
    logic data_ok;
    logic store_ok;
    logic misaligned;
    logic leaf_ok;

    assign pte_v   = pte_i[0];
    assign pte_r   = pte_i[1];
    assign pte_w   = pte_i[2];
    assign pte_x   = pte_i[3];
    assign pte_a   = pte_i[6];
    assign pte_d   = pte_i[7];
    assign pte_ppn = pte_i[`PTW_PTEW-1 -: `PTW_PPNW];

    // ----------------------------------------
    // leaf permission checks
    // ----------------------------------------
    // not valid, or the reserved write-only encoding
    assign invalid = ~pte_v | (~pte_r & pte_w);
    assign is_leaf = pte_r | pte_x;

    // fetch needs x, access flag managed by software
    assign instr_ok = pte_x & pte_a;
    // loads may read x pages when mxr is set
    assign data_ok  = pte_a & (pte_r | (pte_x & mxr_i));
    // stores also want w and an already set dirty bit
    assign store_ok = ~is_store_i | (pte_w & pte_d);

    // a 4M leaf must have ppn[0] cleared
    assign misaligned = (level_i == lvl_1) && (pte_ppn[`PTW_VPNW-1:0] != '0);

    assign leaf_ok = ~misaligned & (is_instr_i ? instr_ok : (data_ok & store_ok));

    // ----------------------------------------
    // classification
    // ----------------------------------------
    always_comb begin
        if (invalid) begin
            verdict_o = verdict_fault;
        end else if (is_leaf) begin
            verdict_o = leaf_ok ? verdict_leaf_ok : verdict_fault;
        end else if (level_i == lvl_1) begin
            // pointer into the level 2 table
            verdict_o = verdict_next_level;
        end else begin
            // pointer found at the last level
            verdict_o = verdict_fault;
        end
    end

endmodule

//--- rtl/ptw_walk_fsm.sv
`timescale 1ns/10ps

`include "sv32_ptw_consts.svh"

module ptw_walk_fsm import sv32_ptw_pkg::*; (
    input  logic         clk_i,
    input  logic         rst_ni,
    input  logic         flush_i,
    input  logic         start_i,
    input  paddr_t       root_pptr_i,
    input  vaddr_t       walk_vaddr_i,
    input  pte_verdict_e verdict_i,
    input  logic         mem_gnt_i,
    input  logic         mem_rvalid_i,
    input  pte_word_t    mem_rdata_i,
    output pte_word_t    pte_o,
    output logic         pte_valid_o,
    output ptw_level_e   level_o,
    output logic         leaf_commit_o,
    output logic         idle_o,
    output logic         ptw_active_o,
    output logic         mem_req_o,
    output paddr_t       mem_addr_o,
    output logic         ptw_error_o
);

    walk_state_e state_q;
    walk_state_e state_d;
    ptw_level_e  level_q;
    ptw_level_e  level_d;
    paddr_t      pptr_q;
    paddr_t      pptr_d;
    logic        rvalid_q;
    pte_word_t   rdata_q;
    logic        judging;
    logic        outstanding;

    // ----------------------------------------
    // read response register
    // ----------------------------------------
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            rvalid_q <= 1'b0;
        end else begin
            rvalid_q <= mem_rvalid_i;
        end
    end

    always_ff @(posedge clk_i) begin
        rdata_q <= mem_rdata_i;
    end

    // a pte is judged in lookup once its registered rvalid is seen
    assign judging = (state_q == st_pte_lookup) && rvalid_q;

    // a granted read whose data has not come back yet
    assign outstanding = ((state_q == st_pte_lookup) && !rvalid_q)
                       || ((state_q == st_wait_grant) && mem_gnt_i)
                       || ((state_q == st_wait_rvalid) && !rvalid_q);

    // ----------------------------------------
    // next state
    // ----------------------------------------
    always_comb begin
        state_d = state_q;
        level_d = level_q;
        pptr_d  = pptr_q;

        case (state_q)
            st_idle: begin
                // every walk starts at the root table
                level_d = lvl_1;
                if (start_i) begin
                    state_d = st_wait_grant;
                end
            end
            st_wait_grant: begin
                if (mem_gnt_i) begin
                    state_d = st_pte_lookup;
                end
            end
            st_pte_lookup: begin
                if (rvalid_q) begin
                    case (verdict_i)
                        verdict_leaf_ok: state_d = st_idle;
                        verdict_next_level: begin
                            // level 2 pte at pte.ppn * 4096 + vpn[0] * 4
                            level_d = lvl_2;
                            pptr_d  = {rdata_q[`PTW_PTEW-1 -: `PTW_PPNW],
                                       walk_vaddr_i[`PTW_PGOFF +: `PTW_VPNW], 2'b00};
                            state_d = st_wait_grant;
                        end
                        default: state_d = st_prop_error;
                    endcase
                end
            end
            st_prop_error: state_d = st_idle;
            st_wait_rvalid: begin
                if (rvalid_q) begin
                    state_d = st_idle;
                end
            end
            default: state_d = st_idle;
        endcase

        // flush drains a read that is still in flight
        if (flush_i) begin
            state_d = outstanding ? st_wait_rvalid : st_idle;
        end
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            state_q <= st_idle;
            level_q <= lvl_1;
        end else begin
            state_q <= state_d;
            level_q <= level_d;
        end
    end

    always_ff @(posedge clk_i) begin
        pptr_q <= pptr_d;
    end

    // ----------------------------------------
    // outputs
    // ----------------------------------------
    assign pte_o         = rdata_q;
    assign pte_valid_o   = judging;
    assign level_o       = level_q;
    assign leaf_commit_o = judging && (verdict_i == verdict_leaf_ok) && !flush_i;
    assign ptw_error_o   = (state_q == st_prop_error) && !flush_i;
    // no new walk is accepted in a flush cycle
    assign idle_o        = (state_q == st_idle) && !flush_i;
    assign ptw_active_o  = (state_q != st_idle);

    // level 1 address comes straight from the latched root pointer
    assign mem_req_o  = (state_q == st_wait_grant);
    assign mem_addr_o = (level_q == lvl_1) ? root_pptr_i : pptr_q;

endmodule

//--- rtl/tlb_update_gen.sv
`timescale 1ns/10ps

`include "sv32_ptw_consts.svh"

module tlb_update_gen import sv32_ptw_pkg::*; (
    input  logic       clk_i,
    input  logic       rst_ni,
    input  logic       start_i,
    input  pte_word_t  pte_i,
    input  logic       pte_valid_i,
    input  ptw_level_e level_i,
    input  logic       leaf_commit_i,
    input  logic       is_instr_i,
    input  vaddr_t     walk_vaddr_i,
    input  asid_t      walk_asid_i,
    output logic       itlb_update_valid_o,
    output logic       dtlb_update_valid_o,
    output vpn_t       update_vpn_o,
    output asid_t      update_asid_o,
    output logic       update_is_4m_o,
    output pte_word_t  update_content_o,
    output vaddr_t     update_vaddr_o,
    output logic       walking_instr_o
);

    logic global_q;

    // sticky global flag, a global pointer makes the whole subtree global
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            global_q <= 1'b0;
        end else if (start_i) begin
            global_q <= 1'b0;
        end else if (pte_valid_i && pte_i[`PTW_G_BIT]) begin
            global_q <= 1'b1;
        end
    end

    // ----------------------------------------
    // update bundle
    // ----------------------------------------
    // steer the commit by walk kind
    assign itlb_update_valid_o = leaf_commit_i & is_instr_i;
    assign dtlb_update_valid_o = leaf_commit_i & ~is_instr_i;

    assign update_vpn_o     = walk_vaddr_i[`PTW_VLEN-1:`PTW_PGOFF];
    assign update_asid_o    = walk_asid_i;
    // leaf found in the root table maps a 4M superpage
    assign update_is_4m_o   = (level_i == lvl_1);
    assign update_content_o = pte_i | (pte_word_t'(global_q) << `PTW_G_BIT);
    assign update_vaddr_o   = walk_vaddr_i;
    assign walking_instr_o  = is_instr_i;

endmodule

//--- rtl/sv32_ptw_top.sv
`timescale 1ns/10ps

module sv32_ptw_top import sv32_ptw_pkg::*; (
    input  logic      clk_i,
    input  logic      rst_ni,
    input  logic      flush_i,
    input  logic      enable_translation_i,
    input  logic      en_ld_st_translation_i,
    input  logic      lsu_is_store_i,
    input  logic      mxr_i,
    input  logic      itlb_access_i,
    input  logic      itlb_hit_i,
    input  vaddr_t    itlb_vaddr_i,
    input  logic      dtlb_access_i,
    input  logic      dtlb_hit_i,
    input  vaddr_t    dtlb_vaddr_i,
    input  asid_t     asid_i,
    input  ppn_t      satp_ppn_i,
    // page table read port
    output logic      mem_req_o,
    output paddr_t    mem_addr_o,
    input  logic      mem_gnt_i,
    input  logic      mem_rvalid_i,
    input  pte_word_t mem_rdata_i,
    // tlb refill
    output logic      itlb_update_valid_o,
    output logic      dtlb_update_valid_o,
    output vpn_t      update_vpn_o,
    output asid_t     update_asid_o,
    output logic      update_is_4m_o,
    output pte_word_t update_content_o,
    output vaddr_t    update_vaddr_o,
    output logic      walking_instr_o,
    // status and perf counters
    output logic      ptw_active_o,
    output logic      ptw_error_o,
    output logic      itlb_miss_o,
    output logic      dtlb_miss_o
);

    logic         idle;
    logic         start;
    logic         is_instr;
    vaddr_t       walk_vaddr;
    asid_t        walk_asid;
    paddr_t       root_pptr;
    pte_word_t    pte;
    logic         pte_valid;
    ptw_level_e   level;
    logic         leaf_commit;
    pte_verdict_e verdict;

    ptw_miss_arbiter u_arbiter (
        .clk_i(clk_i), .rst_ni(rst_ni), .idle_i(idle),
        .enable_translation_i(enable_translation_i),
        .en_ld_st_translation_i(en_ld_st_translation_i),
        .itlb_access_i(itlb_access_i), .itlb_hit_i(itlb_hit_i), .itlb_vaddr_i(itlb_vaddr_i),
        .dtlb_access_i(dtlb_access_i), .dtlb_hit_i(dtlb_hit_i), .dtlb_vaddr_i(dtlb_vaddr_i),
        .asid_i(asid_i), .satp_ppn_i(satp_ppn_i),
        .start_o(start), .is_instr_o(is_instr), .walk_vaddr_o(walk_vaddr),
        .walk_asid_o(walk_asid), .root_pptr_o(root_pptr),
        .itlb_miss_o(itlb_miss_o), .dtlb_miss_o(dtlb_miss_o)
    );

    ptw_walk_fsm u_walk_fsm (
        .clk_i(clk_i), .rst_ni(rst_ni), .flush_i(flush_i), .start_i(start),
        .root_pptr_i(root_pptr), .walk_vaddr_i(walk_vaddr), .verdict_i(verdict),
        .mem_gnt_i(mem_gnt_i), .mem_rvalid_i(mem_rvalid_i), .mem_rdata_i(mem_rdata_i),
        .pte_o(pte), .pte_valid_o(pte_valid), .level_o(level), .leaf_commit_o(leaf_commit),
        .idle_o(idle), .ptw_active_o(ptw_active_o), .mem_req_o(mem_req_o),
        .mem_addr_o(mem_addr_o), .ptw_error_o(ptw_error_o)
    );

    pte_checker u_checker (
        .pte_i(pte), .level_i(level), .is_instr_i(is_instr),
        .is_store_i(lsu_is_store_i), .mxr_i(mxr_i), .verdict_o(verdict)
    );

    tlb_update_gen u_update_gen (
        .clk_i(clk_i), .rst_ni(rst_ni), .start_i(start), .pte_i(pte),
        .pte_valid_i(pte_valid), .level_i(level), .leaf_commit_i(leaf_commit),
        .is_instr_i(is_instr), .walk_vaddr_i(walk_vaddr), .walk_asid_i(walk_asid),
        .itlb_update_valid_o(itlb_update_valid_o), .dtlb_update_valid_o(dtlb_update_valid_o),
        .update_vpn_o(update_vpn_o), .update_asid_o(update_asid_o),
        .update_is_4m_o(update_is_4m_o), .update_content_o(update_content_o),
        .update_vaddr_o(update_vaddr_o), .walking_instr_o(walking_instr_o)
    );

endmodule

//--- dv/sv32_ptw_tb.sv
`timescale 1ns/10ps

module sv32_ptw_tb import sv32_ptw_pkg::*; ();

    // row kinds and expected walk outcomes
    localparam int side_itlb = 0;
    localparam int side_dtlb = 1;
    localparam int side_both = 2;
    localparam int out_itlb  = 0;
    localparam int out_dtlb  = 1;
    localparam int out_err   = 2;
    localparam int out_none  = 3;
    localparam ppn_t satp_ppn = 22'h00080;

    logic      clk_i, rst_ni, flush_i, enable_translation_i, en_ld_st_translation_i;
    logic      lsu_is_store_i, mxr_i, itlb_access_i, itlb_hit_i, dtlb_access_i, dtlb_hit_i;
    vaddr_t    itlb_vaddr_i, dtlb_vaddr_i, update_vaddr_o;
    asid_t     asid_i, update_asid_o;
    ppn_t      satp_ppn_i;
    logic      mem_req_o, mem_gnt_i, mem_rvalid_i;
    paddr_t    mem_addr_o;
    pte_word_t mem_rdata_i, update_content_o;
    logic      itlb_update_valid_o, dtlb_update_valid_o, update_is_4m_o, walking_instr_o;
    logic      ptw_active_o, ptw_error_o, itlb_miss_o, dtlb_miss_o;
    vpn_t      update_vpn_o;

    // case table with one entry per row in each queue
    string     name_q[$];
    int        side_q[$], outcome_q[$];
    logic      store_q[$], mxr_q[$], is_4m_q[$];
    vaddr_t    vaddr_q[$];
    pte_word_t pte1_q[$], pte2_q[$], content_q[$];

    // page table model with two address/data slots per row
    paddr_t    tbl_addr[2];
    pte_word_t tbl_data[2];
    logic [15:0] lfsr_q = 16'd44459;

    int        n_miss_i, n_miss_d, n_upd_i, n_upd_d, n_err, n_grant, n_rvalid;
    pte_word_t snap_content;
    logic      snap_4m, snap_instr;
    vpn_t      snap_vpn;
    asid_t     snap_asid;
    vaddr_t    snap_vaddr;
    int        check_fails, bad_tests, cycles, cycle_limit;
    int        rvalid_cyc, active_cyc;
    string     cur_name = "reset";

    sv32_ptw_top DUT (.*);

    initial begin
        clk_i = 1'b0;
        forever #10 clk_i = ~clk_i;
    end

    // 16 bit fibonacci lfsr with taps 16 14 13 11
    function automatic int rand_bits(input int nbits);
        int   val;
        logic fb;
        val = 0;
        for (int k = 0; k < nbits; k++) begin
            fb     = lfsr_q[15] ^ lfsr_q[13] ^ lfsr_q[12] ^ lfsr_q[10];
            lfsr_q = {lfsr_q[14:0], fb};
            val    = (val << 1) | fb;
        end
        return val;
    endfunction

    function automatic pte_word_t read_table(input paddr_t addr);
        pte_word_t data;
        // unmapped words read as zero and so as an invalid pte
        data = '0;
        for (int k = 0; k < 2; k++) begin
            if (tbl_addr[k] == addr) data = tbl_data[k];
        end
        return data;
    endfunction

    task automatic add_case(input string name, input int side, input logic store,
                            input logic mxr, input vaddr_t vaddr, input pte_word_t pte1,
                            input pte_word_t pte2, input int outcome,
                            input pte_word_t content, input logic is_4m);
        name_q.push_back(name);
        side_q.push_back(side);
        store_q.push_back(store);
        mxr_q.push_back(mxr);
        vaddr_q.push_back(vaddr);
        pte1_q.push_back(pte1);
        pte2_q.push_back(pte2);
        outcome_q.push_back(outcome);
        content_q.push_back(content);
        is_4m_q.push_back(is_4m);
    endtask

    task automatic compare_field(input string field, input logic [31:0] exp,
                                 input logic [31:0] act);
        if (exp !== act) begin
            $display("ERR %s %s: expected %h, actual %h", cur_name, field, exp, act);
            check_fails++;
        end
    endtask

    // ----------------------------------------
    // memory model answering with grant after 0..3 cycles and rvalid 1..3 cycles later
    // ----------------------------------------
    initial begin : mem_model
        paddr_t addr;
        int     delay;
        mem_gnt_i    = 1'b0;
        mem_rvalid_i = 1'b0;
        mem_rdata_i  = '0;
        forever begin
            @(posedge clk_i);
            if (mem_req_o) begin
                addr  = mem_addr_o;
                delay = rand_bits(2);
                repeat (delay) @(posedge clk_i);
                mem_gnt_i <= 1'b1;
                @(posedge clk_i);
                mem_gnt_i <= 1'b0;
                delay = rand_bits(2) % 3 + 1;
                repeat (delay - 1) @(posedge clk_i);
                mem_rvalid_i <= 1'b1;
                mem_rdata_i  <= read_table(addr);
                @(posedge clk_i);
                mem_rvalid_i <= 1'b0;
            end
        end
    end

    // event counters sampled mid-cycle where outputs are settled
    always @(negedge clk_i) begin
        if (itlb_miss_o) n_miss_i++;
        if (dtlb_miss_o) n_miss_d++;
        if (ptw_error_o) n_err++;
        if (mem_req_o && mem_gnt_i) n_grant++;
        if (mem_rvalid_i) begin
            n_rvalid++;
            rvalid_cyc = cycles;
        end
        if (ptw_active_o) active_cyc = cycles;
        if (itlb_update_valid_o) n_upd_i++;
        if (dtlb_update_valid_o) n_upd_d++;
        if (itlb_update_valid_o || dtlb_update_valid_o) begin
            snap_content = update_content_o;
            snap_4m      = update_is_4m_o;
            snap_vpn     = update_vpn_o;
            snap_asid    = update_asid_o;
            snap_vaddr   = update_vaddr_o;
            snap_instr   = walking_instr_o;
        end
    end

    initial begin : watchdog
        wait (cycle_limit > 0);
        while (cycles < cycle_limit) begin
            @(posedge clk_i);
            cycles++;
        end
        $display("timeout after %0d cycles, test %s did not complete", cycles, cur_name);
        $display("sim failed");
        $finish;
    end

    // ----------------------------------------
    // main sequence
    // ----------------------------------------
    initial begin : main_seq
        int fails_before, ui0, ud0, er0, mi0, md0, act, n_ev;
        rst_ni = 1'b0;
        flush_i = 1'b0;
        enable_translation_i = 1'b1;
        en_ld_st_translation_i = 1'b1;
        lsu_is_store_i = 1'b0;
        mxr_i = 1'b0;
        {itlb_access_i, itlb_hit_i, dtlb_access_i, dtlb_hit_i} = 4'b0000;
        itlb_vaddr_i = '0;
        dtlb_vaddr_i = '0;
        asid_i = '0;
        satp_ppn_i = satp_ppn;

        add_case("leaf_4m", side_itlb, 1'b0, 1'b0, 32'h00401234, 32'h00100049, 32'h0,
                 out_itlb, 32'h00100049, 1'b1);
        // global pointer then a 4k read leaf
        add_case("load_4k_g", side_dtlb, 1'b0, 1'b0, 32'h00c05678, 32'h00080021,
                 32'h048d1443, out_dtlb, 32'h048d1463, 1'b0);
        add_case("bad_v", side_dtlb, 1'b0, 1'b0, 32'h01000000, 32'h00100048, 32'h0,
                 out_err, 32'h0, 1'b0);
        add_case("w_only", side_dtlb, 1'b0, 1'b0, 32'h01400000, 32'h00100045, 32'h0,
                 out_err, 32'h0, 1'b0);
        add_case("misalign", side_dtlb, 1'b0, 1'b0, 32'h01800000, 32'h00100443, 32'h0,
                 out_err, 32'h0, 1'b0);
        add_case("st_no_d", side_dtlb, 1'b1, 1'b0, 32'h01c00000, 32'h00100047, 32'h0,
                 out_err, 32'h0, 1'b0);
        add_case("x_fetch", side_itlb, 1'b0, 1'b0, 32'h02000000, 32'h00100043, 32'h0,
                 out_err, 32'h0, 1'b0);
        add_case("ptr_l2", side_dtlb, 1'b0, 1'b0, 32'h02403000, 32'h00080001, 32'h00090001,
                 out_err, 32'h0, 1'b0);
        // flushed right after the first grant
        add_case("flush", side_dtlb, 1'b0, 1'b0, 32'h02805000, 32'h00080021, 32'h048d1443,
                 out_none, 32'h0, 1'b0);
        add_case("xo_nomxr", side_dtlb, 1'b0, 1'b0, 32'h02c00000, 32'h00100049, 32'h0,
                 out_err, 32'h0, 1'b0);
        add_case("xo_mxr", side_dtlb, 1'b0, 1'b1, 32'h02c00000, 32'h00100049, 32'h0,
                 out_dtlb, 32'h00100049, 1'b1);
        add_case("prio", side_both, 1'b0, 1'b0, 32'h03000000, 32'h00100043, 32'h0,
                 out_dtlb, 32'h00100043, 1'b1);
        // worst walk is two levels of 3+3+3 cycles plus per row overhead
        cycle_limit = name_q.size() * (2 * (3 + 3 + 3) + 12) + 40;

        repeat (3) @(posedge clk_i);
        if (mem_req_o | itlb_update_valid_o | dtlb_update_valid_o | ptw_error_o
            | itlb_miss_o | dtlb_miss_o | ptw_active_o) begin
            $display("outputs are not low during reset");
            check_fails++;
        end
        rst_ni <= 1'b1;

        for (int i = 0; i < name_q.size(); i++) begin
            cur_name     = name_q[i];
            fails_before = check_fails;
            tbl_addr[0]  = {satp_ppn, vaddr_q[i][31:22], 2'b00};
            tbl_data[0]  = pte1_q[i];
            tbl_addr[1]  = {pte1_q[i][31:10], vaddr_q[i][21:12], 2'b00};
            tbl_data[1]  = pte2_q[i];
            {ui0, ud0, er0, mi0, md0} = {n_upd_i, n_upd_d, n_err, n_miss_i, n_miss_d};

            @(posedge clk_i);
            lsu_is_store_i <= store_q[i];
            mxr_i          <= mxr_q[i];
            asid_i         <= asid_t'(9'h100 + i);
            itlb_access_i  <= (side_q[i] != side_dtlb);
            dtlb_access_i  <= (side_q[i] != side_itlb);
            itlb_vaddr_i   <= (side_q[i] == side_itlb) ? vaddr_q[i] : ~vaddr_q[i];
            dtlb_vaddr_i   <= vaddr_q[i];
            // hold the miss until it is taken
            do @(posedge clk_i); while (n_miss_i + n_miss_d == mi0 + md0);
            itlb_access_i <= 1'b0;
            dtlb_access_i <= 1'b0;

            if (outcome_q[i] == out_none) begin
                do @(posedge clk_i); while (!(mem_req_o && mem_gnt_i));
                flush_i <= 1'b1;
                @(posedge clk_i);
                flush_i <= 1'b0;
                do @(posedge clk_i); while (ptw_active_o);
                compare_field("rvalids", n_grant, n_rvalid);
                // the drained read is registered for one cycle before the walker idles
                compare_field("drain_end", rvalid_cyc + 1, active_cyc);
            end else begin
                do @(posedge clk_i); while (n_upd_i + n_upd_d + n_err == ui0 + ud0 + er0);
                @(posedge clk_i);
                if (ptw_active_o) begin
                    $display("test %s: walker still active after the walk ended", cur_name);
                    check_fails++;
                end
            end

            n_ev = (n_upd_i - ui0) + (n_upd_d - ud0) + (n_err - er0);
            act  = (n_upd_i != ui0) ? out_itlb : (n_upd_d != ud0) ? out_dtlb :
                   (n_err != er0) ? out_err : out_none;
            compare_field("outcome", outcome_q[i], act);
            compare_field("events", (outcome_q[i] == out_none) ? 0 : 1, n_ev);
            compare_field("itlb_miss", (side_q[i] == side_itlb) ? 1 : 0, n_miss_i - mi0);
            compare_field("dtlb_miss", (side_q[i] == side_itlb) ? 0 : 1, n_miss_d - md0);
            if (outcome_q[i] == out_itlb || outcome_q[i] == out_dtlb) begin
                compare_field("content", content_q[i], snap_content);
                compare_field("is_4m", is_4m_q[i], snap_4m);
                compare_field("vpn", vaddr_q[i][31:12], snap_vpn);
                compare_field("vaddr", vaddr_q[i], snap_vaddr);
                compare_field("asid", 9'h100 + i, snap_asid);
                compare_field("walking_instr", outcome_q[i] == out_itlb, snap_instr);
            end

            if (check_fails == fails_before) begin
                $display("test %s ok", cur_name);
            end else begin
                $display("test %s FAILED", cur_name);
                bad_tests++;
            end
        end

        $display("%0d tests, %0d failed, %0d check errors", name_q.size(), bad_tests,
                 check_fails);
        if (check_fails == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule

//--- sv32_ptw.f
+incdir+rtl
rtl/sv32_ptw_pkg.sv
rtl/ptw_miss_arbiter.sv
rtl/pte_checker.sv
rtl/ptw_walk_fsm.sv
rtl/tlb_update_gen.sv
rtl/sv32_ptw_top.sv
dv/sv32_ptw_tb.sv
